// ==== sim.f ====
+incdir+.
dbg_i2c_pkg.sv
dbg_i2c_byte_if.sv
dbg_i2c_line_filter.sv
dbg_i2c_link.sv
dbg_i2c_reg_access.sv
dbg_i2c_top.sv
tb_dbg_i2c_checker.sv
tb_dbg_i2c.sv

// ==== Makefile ====
# Verilator build and run for the I2C debug slave

VERILATOR ?= verilator
TOP       ?= tb_dbg_i2c
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dbg_i2c_settings.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_dbg_i2c.sv ====
// I2C debug slave testbench

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

module tb_dbg_i2c;

  import dbg_i2c_pkg::*;

  localparam int QUARTER     = 8;      // dbg_clk cycles per quarter bit
  localparam logic [`DBG_I2C_DEV_ADDR_W-1:0] DEV_ADDR = 7'h2a;
  localparam int N_TRANS     = 6;      // Transfers over all tests
  localparam int WATCHDOG_NS = N_TRANS * 6 * 9 * 32 * 20 + 20000;  // Bytes, bits, cycles, ns

  logic                           dbg_clk = 1'b0;
  logic                           dbg_rst;
  logic                           scl_m;     // Master SCL
  logic                           sda_m;     // Open-drain master SDA
  wire                            sda_bus;   // Wired-AND of both drivers
  logic [`DBG_I2C_DEV_ADDR_W-1:0] dbg_i2c_addr;
  logic [`DBG_I2C_DATA_W-1:0]     dbg_dout = '0;
  logic                           dbg_i2c_sda_out;
  logic [`DBG_I2C_REG_ADDR_W-1:0] dbg_addr;
  logic [`DBG_I2C_DATA_W-1:0]     dbg_din;
  logic                           dbg_wr;
  logic                           dbg_rd;
  logic [`DBG_I2C_REG_ADDR_W-1:0] exp_addr;
  logic [`DBG_I2C_BYTE_W-1:0]     exp_lo;
  logic [`DBG_I2C_BYTE_W-1:0]     exp_hi;
  logic                           exp_bw;
  int                             error_count;
  logic [`DBG_I2C_DATA_W-1:0]     reg_model [0:63];  // Debug register file
  integer                         seed = 32'hc551c36c;

  always #10 dbg_clk = ~dbg_clk;  // 20 ns period

  assign sda_bus = sda_m & dbg_i2c_sda_out;

  // Read data follows the address one clock late
  always @(posedge dbg_clk) dbg_dout <= reg_model[dbg_addr];

  dbg_i2c_top dut0 (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_i2c_scl     (scl_m),
    .dbg_i2c_sda_in  (sda_bus),
    .dbg_i2c_addr    (dbg_i2c_addr),
    .dbg_dout        (dbg_dout),
    .dbg_i2c_sda_out (dbg_i2c_sda_out),
    .dbg_addr        (dbg_addr),
    .dbg_din         (dbg_din),
    .dbg_wr          (dbg_wr),
    .dbg_rd          (dbg_rd)
  );

  tb_dbg_i2c_checker chk0 (
    .dbg_clk     (dbg_clk),
    .dbg_rst     (dbg_rst),
    .dbg_wr      (dbg_wr),
    .dbg_rd      (dbg_rd),
    .dbg_addr    (dbg_addr),
    .dbg_din     (dbg_din),
    .exp_addr    (exp_addr),
    .exp_lo      (exp_lo),
    .exp_hi      (exp_hi),
    .exp_bw      (exp_bw),
    .error_count (error_count)
  );

  //////////////////////////////////////////////////
  // I2C master
  //////////////////////////////////////////////////

  task automatic quarter();
    repeat (QUARTER) @(posedge dbg_clk);
  endtask

  task automatic send_bit(input logic b);
    sda_m <= b;  // Changes only while SCL is low
    quarter();
    scl_m <= 1'b1;
    quarter();
    quarter();
    scl_m <= 1'b0;
    quarter();
  endtask

  task automatic recv_bit(output logic b);
    sda_m <= 1'b1;  // Released
    quarter();
    scl_m <= 1'b1;
    quarter();
    b = sda_bus;    // Middle of SCL high
    quarter();
    scl_m <= 1'b0;
    quarter();
  endtask

  // Works from idle and as repeated START
  task automatic i2c_start();
    sda_m <= 1'b1;
    quarter();
    scl_m <= 1'b1;
    quarter();
    sda_m <= 1'b0;
    quarter();
    scl_m <= 1'b0;
    quarter();
  endtask

  task automatic i2c_stop();
    sda_m <= 1'b0;
    quarter();
    scl_m <= 1'b1;
    quarter();
    sda_m <= 1'b1;  // Rises with SCL high
    quarter();
    quarter();
  endtask

  task automatic write_byte(input logic [7:0] data, output logic ack);
    logic nack_bit;
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);  // MSB first
    end
    recv_bit(nack_bit);
    ack = ~nack_bit;
  endtask

  task automatic read_byte(output logic [7:0] data, input logic nack);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      recv_bit(b);
      data[i] = b;
    end
    send_bit(nack);
  endtask

  //////////////////////////////////////////////////
  // Register transfers
  //////////////////////////////////////////////////

  task automatic write_reg(input logic [5:0] addr, input logic [7:0] lo, input logic [7:0] hi,
                           input logic bw);
    dbg_cmd_t cmd;
    logic     ack;
    cmd = '{write: 1'b1, byte_width: bw, addr: addr};
    exp_addr <= addr;
    exp_lo   <= lo;
    exp_hi   <= hi;
    exp_bw   <= bw;
    i2c_start();
    write_byte({DEV_ADDR, 1'b0}, ack);
    chk0.expect_true(ack, "no ACK on the device address");
    write_byte(cmd, ack);
    chk0.expect_true(ack, "no ACK on the command byte");
    write_byte(lo, ack);
    chk0.expect_true(ack, "no ACK on the low data byte");
    if (!bw) begin
      write_byte(hi, ack);
      chk0.expect_true(ack, "no ACK on the high data byte");
    end
    i2c_stop();
  endtask

  // Command write, repeated START, then the read bytes
  task automatic read_reg(input logic [5:0] addr, input logic bw, output logic [7:0] lo,
                          output logic [7:0] hi);
    dbg_cmd_t cmd;
    logic     ack;
    cmd = '{write: 1'b0, byte_width: bw, addr: addr};
    exp_addr <= addr;
    hi = '0;
    i2c_start();
    write_byte({DEV_ADDR, 1'b0}, ack);
    chk0.expect_true(ack, "no ACK on the device address");
    write_byte(cmd, ack);
    chk0.expect_true(ack, "no ACK on the command byte");
    i2c_start();
    write_byte({DEV_ADDR, 1'b1}, ack);
    chk0.expect_true(ack, "no ACK on the device address with the read bit");
    read_byte(lo, bw);  // NACK if this is the last byte
    if (!bw) begin
      read_byte(hi, 1'b1);
    end
    i2c_stop();
  endtask

  // Full write addressed to another device
  task automatic foreign_transfer(input logic [7:0] cmd_byte);
    logic ack;
    i2c_start();
    write_byte({DEV_ADDR ^ 7'h15, 1'b0}, ack);
    chk0.expect_true(!ack, "slave pulled SDA low for a foreign device address");
    write_byte(cmd_byte, ack);
    write_byte(8'h5a, ack);
    write_byte(8'ha5, ack);
    i2c_stop();
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [5:0]  addr;
    logic [7:0]  lo;
    logic [7:0]  hi;
    dbg_rst      = 1'b1;
    scl_m        = 1'b1;  // Idle bus
    sda_m        = 1'b1;
    dbg_i2c_addr = DEV_ADDR;
    exp_addr     = '0;
    exp_lo       = '0;
    exp_hi       = '0;
    exp_bw       = 1'b0;
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      reg_model[i] = r[15:0];
    end
    repeat (3) @(posedge dbg_clk);
    dbg_rst <= 1'b0;

    @(posedge dbg_clk);
    chk0.begin_test();
    chk0.compare("dbg_wr", 32'(dbg_wr), 32'd0);
    chk0.compare("dbg_rd", 32'(dbg_rd), 32'd0);
    chk0.compare("dbg_i2c_sda_out", 32'(dbg_i2c_sda_out), 32'd1);
    chk0.compare("dbg_addr", 32'(dbg_addr), 32'd0);
    chk0.compare("dbg_din", 32'(dbg_din), 32'd0);
    chk0.end_test("reset values", 0, 0);

    r = $random(seed);
    chk0.begin_test();
    write_reg(r[5:0], r[13:6], r[21:14], 1'b0);
    chk0.end_test("16-bit write", 1, 0);

    r = $random(seed);
    chk0.begin_test();
    write_reg(r[5:0], r[13:6], r[21:14], 1'b1);  // High byte never sent
    chk0.end_test("8-bit write", 1, 0);

    r = $random(seed);
    addr = r[5:0];
    chk0.begin_test();
    read_reg(addr, 1'b0, lo, hi);
    chk0.compare("sda read low byte", 32'(lo), 32'(reg_model[addr][7:0]));
    chk0.compare("sda read high byte", 32'(hi), 32'(reg_model[addr][15:8]));
    chk0.end_test("16-bit read", 0, 1);

    r = $random(seed);
    addr = r[5:0];
    chk0.begin_test();
    read_reg(addr, 1'b1, lo, hi);
    chk0.compare("sda read low byte", 32'(lo), 32'(reg_model[addr][7:0]));
    chk0.end_test("8-bit read", 0, 1);

    r = $random(seed);
    chk0.begin_test();
    foreign_transfer({2'b10, r[5:0]});  // Write command
    chk0.end_test("foreign device address", 0, 0);

    chk0.begin_test();
    write_reg(r[11:6], r[19:12], r[27:20], 1'b0);
    chk0.end_test("write after foreign address", 1, 0);

    chk0.report();
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the I2C transfers did not finish", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== tb_dbg_i2c_checker.sv ====
// I2C debug slave checker

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

module tb_dbg_i2c_checker (
  input  logic                           dbg_clk,
  input  logic                           dbg_rst,
  input  logic                           dbg_wr,
  input  logic                           dbg_rd,
  input  logic [`DBG_I2C_REG_ADDR_W-1:0] dbg_addr,
  input  logic [`DBG_I2C_DATA_W-1:0]     dbg_din,
  input  logic [`DBG_I2C_REG_ADDR_W-1:0] exp_addr,  // Command address of the running test
  input  logic [`DBG_I2C_BYTE_W-1:0]     exp_lo,
  input  logic [`DBG_I2C_BYTE_W-1:0]     exp_hi,
  input  logic                           exp_bw,    // 8-bit write when set
  output int                             error_count
);

  int check_count = 0;
  int test_count  = 0;
  int test_errors = 0;  // Error count when the test began
  int wr_seen     = 0;
  int rd_seen     = 0;

  initial error_count = 0;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Low byte alone for 8-bit, else high byte joined to low byte
  function automatic logic [`DBG_I2C_DATA_W-1:0] expected_din(
    input logic [`DBG_I2C_BYTE_W-1:0] lo,
    input logic [`DBG_I2C_BYTE_W-1:0] hi,
    input logic                       byte_width
  );
    if (byte_width) begin
      return {{`DBG_I2C_BYTE_W{1'b0}}, lo};
    end
    return {hi, lo};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    check_count++;
    if (cond !== 1'b1) begin
      error_count++;
      $display("Error: %s at %0t", what, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Strobe watch
  //////////////////////////////////////////////////

  // Strobes are registered, so the pre-edge value is stable here
  always @(posedge dbg_clk) begin
    if (!dbg_rst && dbg_wr) begin
      wr_seen++;
      compare("dbg_addr", 32'(dbg_addr), 32'(exp_addr));
      compare("dbg_din", 32'(dbg_din), 32'(expected_din(exp_lo, exp_hi, exp_bw)));
    end
    if (!dbg_rst && dbg_rd) begin
      rd_seen++;
      compare("dbg_addr", 32'(dbg_addr), 32'(exp_addr));  // Address of the read
    end
  end

  task automatic begin_test();
    wr_seen     = 0;
    rd_seen     = 0;
    test_errors = error_count;
  endtask

  // Strobe counts, then one line for the test
  task automatic end_test(input string name, input int exp_wr, input int exp_rd);
    expect_true(wr_seen == exp_wr,
                $sformatf("expected %0d dbg_wr pulse(s) but saw %0d", exp_wr, wr_seen));
    expect_true(rd_seen == exp_rd,
                $sformatf("expected %0d dbg_rd pulse(s) but saw %0d", exp_rd, rd_seen));
    test_count++;
    if (error_count == test_errors) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: %0d error(s)", test_count, name, error_count - test_errors);
    end
  endtask

  task automatic report();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
  endtask

endmodule

// ==== dbg_i2c_top.sv ====
// Debug I2C slave top level

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

module dbg_i2c_top (
  input  logic                           dbg_clk,
  input  logic                           dbg_rst,
  input  logic                           dbg_i2c_scl,
  input  logic                           dbg_i2c_sda_in,
  input  logic [`DBG_I2C_DEV_ADDR_W-1:0] dbg_i2c_addr,     // Our slave address
  input  logic [`DBG_I2C_DATA_W-1:0]     dbg_dout,
  output logic                           dbg_i2c_sda_out,  // Open-drain enable, active low
  output logic [`DBG_I2C_REG_ADDR_W-1:0] dbg_addr,
  output logic [`DBG_I2C_DATA_W-1:0]     dbg_din,
  output logic                           dbg_wr,
  output logic                           dbg_rd
);

  logic scl;
  logic scl_rise;
  logic scl_fall;
  logic sda;
  logic sda_rise;
  logic sda_fall;

  dbg_i2c_byte_if bus0 ();  // Link to command FSM

  // Line conditioning
  dbg_i2c_line_filter scl_filter (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .line_in (dbg_i2c_scl),
    .level   (scl),
    .rise    (scl_rise),
    .fall    (scl_fall)
  );

  dbg_i2c_line_filter sda_filter (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .line_in (dbg_i2c_sda_in),
    .level   (sda),
    .rise    (sda_rise),
    .fall    (sda_fall)
  );

  dbg_i2c_link link0 (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .scl      (scl),
    .scl_rise (scl_rise),
    .scl_fall (scl_fall),
    .sda      (sda),
    .sda_rise (sda_rise),
    .sda_fall (sda_fall),
    .dev_addr (dbg_i2c_addr),
    .sda_out  (dbg_i2c_sda_out),
    .byte_bus (bus0.link)
  );

  dbg_i2c_reg_access access0 (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .dbg_dout (dbg_dout),
    .dbg_addr (dbg_addr),
    .dbg_din  (dbg_din),
    .dbg_wr   (dbg_wr),
    .dbg_rd   (dbg_rd),
    .byte_bus (bus0.access)
  );

endmodule

// ==== dbg_i2c_reg_access.sv ====
// Debug register access FSM

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

module dbg_i2c_reg_access (
  input  logic                           dbg_clk,
  input  logic                           dbg_rst,
  input  logic [`DBG_I2C_DATA_W-1:0]     dbg_dout,  // Read data, held by the unit
  output logic [`DBG_I2C_REG_ADDR_W-1:0] dbg_addr,
  output logic [`DBG_I2C_DATA_W-1:0]     dbg_din,
  output logic                           dbg_wr,
  output logic                           dbg_rd,
  dbg_i2c_byte_if.access                 byte_bus
);

  import dbg_i2c_pkg::*;

  access_state_t              state;
  access_state_t              state_nxt;
  dbg_cmd_t                   cmd;
  logic                       dbg_bw;       // 8-bit access when set
  logic                       cmd_valid;
  logic                       rx_lo_valid;
  logic                       rx_hi_valid;
  logic [`DBG_I2C_BYTE_W-1:0] din_lo;
  logic [`DBG_I2C_BYTE_W-1:0] din_hi;

  assign cmd = dbg_cmd_t'(byte_bus.rx_byte);  // Decode is only used in rx_cmd

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      rx_cmd:     if (byte_bus.rx_done) state_nxt = cmd.write ? rx_byte_lo : tx_byte_lo;
      rx_byte_lo: if (byte_bus.rx_done) state_nxt = dbg_bw ? rx_cmd : rx_byte_hi;
      rx_byte_hi: if (byte_bus.rx_done) state_nxt = rx_cmd;
      tx_byte_lo: if (byte_bus.tx_done) state_nxt = dbg_bw ? rx_cmd : tx_byte_hi;
      tx_byte_hi: if (byte_bus.tx_done) state_nxt = rx_cmd;
      default:    state_nxt = rx_cmd;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= rx_cmd;
    end else begin
      state <= state_nxt;
    end
  end

  assign cmd_valid   = (state == rx_cmd) & byte_bus.rx_done;
  assign rx_lo_valid = (state == rx_byte_lo) & byte_bus.rx_done;
  assign rx_hi_valid = (state == rx_byte_hi) & byte_bus.rx_done;

  //////////////////////////////////////////////////
  // Address, data and strobes
  //////////////////////////////////////////////////

  // Address and width held until the next command
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_addr <= '0;
      dbg_bw   <= 1'b0;
    end else if (cmd_valid) begin
      dbg_addr <= cmd.addr;
      dbg_bw   <= cmd.byte_width;
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      din_lo <= '0;
      din_hi <= '0;
    end else if (rx_lo_valid) begin
      din_lo <= byte_bus.rx_byte;
      din_hi <= '0;  // Stays zero for 8-bit writes
    end else if (rx_hi_valid) begin
      din_hi <= byte_bus.rx_byte;
    end
  end

  assign dbg_din = {din_hi, din_lo};

  // Strobes one clock after the deciding byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_wr <= 1'b0;
      dbg_rd <= 1'b0;
    end else begin
      dbg_wr <= dbg_bw ? rx_lo_valid : rx_hi_valid;  // Last byte of the write
      dbg_rd <= cmd_valid & ~cmd.write;
    end
  end

  // Low byte goes first
  assign byte_bus.tx_byte = (state == tx_byte_hi) ?
                            dbg_dout[`DBG_I2C_DATA_W-1:`DBG_I2C_BYTE_W] :
                            dbg_dout[`DBG_I2C_BYTE_W-1:0];

endmodule

// ==== dbg_i2c_link.sv ====
// I2C bit-level slave

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

module dbg_i2c_link (
  input  logic                          dbg_clk,
  input  logic                          dbg_rst,
  input  logic                          scl,       // Filtered SCL
  input  logic                          scl_rise,
  input  logic                          scl_fall,
  input  logic                          sda,       // Filtered SDA
  input  logic                          sda_rise,
  input  logic                          sda_fall,
  input  logic [`DBG_I2C_DEV_ADDR_W-1:0] dev_addr,
  output logic                          sda_out,   // Low pulls the open-drain bus
  dbg_i2c_byte_if.link                  byte_bus
);

  import dbg_i2c_pkg::*;

  // Only the sentinel left once all eight bits are out
  localparam logic [`DBG_I2C_BYTE_W:0] TX_EMPTY = {1'b1, {`DBG_I2C_BYTE_W{1'b0}}};

  logic                       start_det;
  logic                       stop_det;
  logic                       active_q;
  logic                       active;
  logic                       init;       // Back to address reception
  logic                       addr_nack;  // Address byte is not ours
  link_state_t                state;
  link_state_t                state_nxt;
  logic [`DBG_I2C_BYTE_W:0]   shift_buf;  // Data plus sentinel
  logic [1:0]                 rise_dly;
  logic                       sample;
  logic                       rx_en;
  logic                       rx_shift_done;
  logic                       tx_shift_done;
  logic                       tx_en_pre;
  logic                       rx_init;
  logic                       tx_init;
  logic                       tx_shift;

  //////////////////////////////////////////////////
  // START, STOP and active flag
  //////////////////////////////////////////////////

  assign start_det = sda_fall & scl;  // Also covers repeated START
  assign stop_det  = sda_rise & scl;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      active_q <= 1'b0;
    end else if (start_det) begin
      active_q <= 1'b1;
    end else if (stop_det || addr_nack) begin
      active_q <= 1'b0;
    end
  end

  assign active = active_q & ~stop_det;
  assign init   = ~active | start_det;

  //////////////////////////////////////////////////
  // Bit-level FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    if (init) begin
      state_nxt = rx_addr;
    end else begin
      case (state)
        rx_addr:     if (rx_shift_done && !addr_nack) state_nxt = rx_addr_ack;
        rx_addr_ack: if (scl_fall) state_nxt = shift_buf[0] ? tx_data : rx_data;  // R/W bit
        rx_data:     if (rx_shift_done) state_nxt = rx_data_ack;
        rx_data_ack: if (scl_fall) state_nxt = rx_data;
        tx_data:     if (tx_shift_done) state_nxt = tx_data_ack;
        tx_data_ack: if (scl_fall) state_nxt = sda ? rx_addr : tx_data;  // NACK ends the read
        default:     state_nxt = rx_addr;
      endcase
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= rx_addr;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Shift register
  //////////////////////////////////////////////////

  // Sample point sits two cycles after the SCL rise
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      rise_dly <= 2'b00;
    end else begin
      rise_dly <= {rise_dly[0], scl_rise};
    end
  end

  assign sample = rise_dly[1];

  assign rx_en         = (state == rx_addr) | (state == rx_data);
  assign rx_shift_done = rx_en & scl_fall & shift_buf[`DBG_I2C_BYTE_W];  // Sentinel at the top
  assign tx_shift_done = (state == tx_data) & scl_fall & (shift_buf == TX_EMPTY);

  assign addr_nack = (state == rx_addr) & rx_shift_done &
                     (shift_buf[`DBG_I2C_BYTE_W-1:1] != dev_addr);

  assign rx_init = init |
                   ((state == rx_addr_ack) & scl_fall & ~shift_buf[0]) |
                   ((state == rx_data_ack) & scl_fall);
  // Load the read byte while SCL is high on the ACK bit
  assign tx_init = ((state == rx_addr_ack) & scl_rise & shift_buf[0]) |
                   ((state == tx_data_ack) & scl_rise);

  assign tx_en_pre = (state_nxt == tx_data);
  assign tx_shift  = tx_en_pre & scl_fall & (shift_buf != TX_EMPTY);

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      shift_buf <= {{`DBG_I2C_BYTE_W{1'b0}}, 1'b1};
    end else if (rx_init) begin
      shift_buf <= {{`DBG_I2C_BYTE_W{1'b0}}, 1'b1};  // Empty with the sentinel at bit 0
    end else if (tx_init) begin
      shift_buf <= {byte_bus.tx_byte, 1'b1};
    end else if (rx_en && sample) begin
      shift_buf <= {shift_buf[`DBG_I2C_BYTE_W-1:0], sda};
    end else if (tx_shift) begin
      shift_buf <= {shift_buf[`DBG_I2C_BYTE_W-1:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // SDA drive and byte strobes
  //////////////////////////////////////////////////

  // Changes only while SCL is low
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sda_out <= 1'b1;  // Released
    end else if (scl_fall) begin
      sda_out <= ~((state_nxt == rx_addr_ack) |
                   (state_nxt == rx_data_ack) |
                   (tx_shift & ~shift_buf[`DBG_I2C_BYTE_W]));  // MSB of what is left
    end
  end

  assign byte_bus.rx_done = rx_shift_done & (state == rx_data);  // Address byte excluded
  assign byte_bus.rx_byte = shift_buf[`DBG_I2C_BYTE_W-1:0];
  assign byte_bus.tx_done = tx_shift_done;

endmodule

// ==== dbg_i2c_line_filter.sv ====
// I2C line filter

`timescale 1ns/1ps

module dbg_i2c_line_filter (
  input  logic dbg_clk,
  input  logic dbg_rst,
  input  logic line_in,  // Raw pin
  output logic level,    // Filtered level
  output logic rise,     // One-cycle pulse
  output logic fall      // One-cycle pulse
);

  //////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////

  logic [1:0] sync_q;   // Two-flop synchronizer
  logic [1:0] hist_q;   // Two older samples
  logic       level_q;  // Previous filtered level

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sync_q <= 2'b11;  // Idle bus is high
    end else begin
      sync_q <= {sync_q[0], line_in};
    end
  end

  // Sample history for the vote
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      hist_q <= 2'b11;
    end else begin
      hist_q <= {hist_q[0], sync_q[1]};
    end
  end

  //////////////////////////////////////////////////
  // Majority vote and edges
  //////////////////////////////////////////////////

  // Two out of three wins, kills single-cycle glitches
  assign level = (sync_q[1] & hist_q[0]) |
                 (sync_q[1] & hist_q[1]) |
                 (hist_q[0] & hist_q[1]);

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      level_q <= 1'b1;
      rise    <= 1'b0;
      fall    <= 1'b0;
    end else begin
      level_q <= level;
      rise    <= level & ~level_q;  // Lands one cycle after the level
      fall    <= ~level & level_q;
    end
  end

endmodule

// ==== dbg_i2c_byte_if.sv ====
// Link to register access byte bus

`timescale 1ns/1ps

`include "dbg_i2c_settings.svh"

interface dbg_i2c_byte_if;

  logic                        rx_done;  // Data byte received, single pulse
  logic [`DBG_I2C_BYTE_W-1:0]  rx_byte;  // Valid with rx_done
  logic                        tx_done;  // Transmit byte finished, single pulse
  logic [`DBG_I2C_BYTE_W-1:0]  tx_byte;  // Next byte to send, level

  // Bit-level slave side
  modport link (
    output rx_done,
    output rx_byte,
    output tx_done,
    input  tx_byte
  );

  // Command FSM side
  modport access (
    input  rx_done,
    input  rx_byte,
    input  tx_done,
    output tx_byte
  );

endinterface

// ==== dbg_i2c_pkg.sv ====
// Debug I2C shared types

`include "dbg_i2c_settings.svh"

package dbg_i2c_pkg;

  // Bit-level slave states
  typedef enum logic [2:0] {
    rx_addr     = 3'h0,  // Device address plus R/W bit
    rx_addr_ack = 3'h1,
    rx_data     = 3'h2,  // Byte from master
    rx_data_ack = 3'h3,
    tx_data     = 3'h4,  // Byte to master
    tx_data_ack = 3'h5   // Master ACK or NACK
  } link_state_t;

  // Debug command states
  typedef enum logic [2:0] {
    rx_cmd     = 3'h0,
    rx_byte_lo = 3'h1,
    rx_byte_hi = 3'h2,
    tx_byte_lo = 3'h3,
    tx_byte_hi = 3'h4
  } access_state_t;

  // Command byte, MSB first
  typedef struct packed {
    logic                            write;       // Set for register write
    logic                            byte_width;  // Set for 8-bit access
    logic [`DBG_I2C_REG_ADDR_W-1:0]  addr;
  } dbg_cmd_t;

endpackage

// ==== dbg_i2c_settings.svh ====
// Debug I2C width settings

`ifndef DBG_I2C_SETTINGS_SVH
`define DBG_I2C_SETTINGS_SVH

//////////////////////////////////////////////////
// Debug register side
//////////////////////////////////////////////////

`define DBG_I2C_DATA_W      16  // Debug register word
`define DBG_I2C_REG_ADDR_W  6   // Debug register address

//////////////////////////////////////////////////
// I2C side
//////////////////////////////////////////////////

`define DBG_I2C_DEV_ADDR_W  7   // 7-bit slave address
`define DBG_I2C_BYTE_W      8   // One byte on the wire

`endif
